// File: hw/tmr_pkg.sv
`default_nettype none

package tmr_pkg;

    // register bus geometry
    localparam int BUS_AW = 32;
    localparam int BUS_DW = 32;

    // in-block offset width, each block spans 16 bytes
    localparam int OFS_W = 4;

    // timer register offsets
    localparam logic [OFS_W-1:0] REG_CTRL  = 4'h0;
    localparam logic [OFS_W-1:0] REG_COUNT = 4'h4;
    localparam logic [OFS_W-1:0] REG_VALUE = 4'h8;

    // interrupt controller register offsets
    localparam logic [OFS_W-1:0] REG_IRQ_MASK = 4'h0;
    localparam logic [OFS_W-1:0] REG_IRQ_PEND = 4'h4;
    localparam logic [OFS_W-1:0] REG_IRQ_ID   = 4'h8;

    // block base addresses
    localparam logic [BUS_AW-1:0] BASE_TMR0 = 32'h0000_0000;
    localparam logic [BUS_AW-1:0] BASE_TMR1 = 32'h0000_0010;
    localparam logic [BUS_AW-1:0] BASE_IRQ  = 32'h0000_0020;

    // timer instances behind the decoder
    localparam int N_TMR = 2;

    // timer ctrl fields, lsb first: enable, int enable, pending
    typedef struct packed {
        logic [28:0] spare;
        logic        pend;
        logic        irq_en;
        logic        en;
    } tmr_ctrl_fields_t;

    // ctrl word, seen either as the bus word or as fields
    typedef union packed {
        logic [BUS_DW-1:0] raw;
        tmr_ctrl_fields_t  field;
    } tmr_ctrl_t;

endpackage

`default_nettype wire

// File: hw/tmr_counter.sv
`default_nettype none

module tmr_counter (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  logic [tmr_pkg::OFS_W-1:0]  ofs_i,
    input  logic [tmr_pkg::BUS_DW-1:0] wdata_i,
    output logic [tmr_pkg::BUS_DW-1:0] rdata_o,
    output logic                       int_o
);

    import tmr_pkg::*;

    // enable, int enable, pending and spare bits
    tmr_ctrl_t ctrl_q;

    // free-running count while enabled
    logic [BUS_DW-1:0] count_q;

    // expiry value
    logic [BUS_DW-1:0] value_q;

    // next ctrl word for a bus write
    tmr_ctrl_t ctrl_wr;

    logic ctrl_we;
    logic value_we;
    logic expired;

    assign ctrl_we  = we_i && (ofs_i == REG_CTRL);
    assign value_we = we_i && (ofs_i == REG_VALUE);

    // count has reached the programmed value
    assign expired = ctrl_q.field.en && (count_q >= value_q);

    // pending and int enable both needed
    assign int_o = ctrl_q.field.pend & ctrl_q.field.irq_en;

    // bus write image of ctrl
    always_comb begin
        ctrl_wr.raw = wdata_i;
        // pending is write-1-to-clear, never set by the bus
        ctrl_wr.field.pend = ctrl_q.field.pend & ~wdata_i[2];
    end

    // counter
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (ctrl_q.field.en) begin
            if (expired) begin
                // wrap back to zero on expiry
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end else begin
            // held at zero while stopped
            count_q <= '0;
        end
    end

    // ctrl register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q.raw <= '0;
        end else if (ctrl_we) begin
            // bus write beats a same-cycle expiry
            ctrl_q <= ctrl_wr;
        end else if (expired) begin
            // one-shot: stop and flag
            ctrl_q.field.en   <= 1'b0;
            ctrl_q.field.pend <= 1'b1;
        end
    end

    // expiry value register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            value_q <= '0;
        end else if (value_we) begin
            value_q <= wdata_i;
        end
    end

    // read mux, count is read only
    always_comb begin
        case (ofs_i)
            REG_CTRL: begin
                rdata_o = ctrl_q.raw;
            end
            REG_COUNT: begin
                rdata_o = count_q;
            end
            REG_VALUE: begin
                rdata_o = value_q;
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/tmr_bus_decode.sv
`default_nettype none

module tmr_bus_decode (
    input  logic [tmr_pkg::BUS_AW-1:0]                     addr_i,
    input  logic                                           we_i,
    input  logic [tmr_pkg::N_TMR-1:0][tmr_pkg::BUS_DW-1:0] tmr_rdata_i,
    input  logic [tmr_pkg::BUS_DW-1:0]                     irq_rdata_i,
    output logic [tmr_pkg::N_TMR-1:0]                      tmr_we_o,
    output logic                                           irq_we_o,
    output logic [tmr_pkg::OFS_W-1:0]                      ofs_o,
    output logic [tmr_pkg::BUS_DW-1:0]                     rdata_o
);

    import tmr_pkg::*;

    // block hit per timer
    logic [N_TMR-1:0] tmr_hit;
    logic             irq_hit;

    // match on the upper address bits only
    assign tmr_hit[0] = (addr_i[BUS_AW-1:OFS_W] == BASE_TMR0[BUS_AW-1:OFS_W]);
    assign tmr_hit[1] = (addr_i[BUS_AW-1:OFS_W] == BASE_TMR1[BUS_AW-1:OFS_W]);
    assign irq_hit    = (addr_i[BUS_AW-1:OFS_W] == BASE_IRQ[BUS_AW-1:OFS_W]);

    // offset shared by all blocks
    assign ofs_o = addr_i[OFS_W-1:0];

    // write strobes, at most one since bases differ
    assign tmr_we_o = tmr_hit & {N_TMR{we_i}};
    assign irq_we_o = irq_hit & we_i;

    // read data select
    always_comb begin
        // unmapped reads return zero
        rdata_o = '0;
        for (int i = 0; i < N_TMR; i++) begin
            if (tmr_hit[i]) begin
                rdata_o = tmr_rdata_i[i];
            end
        end
        if (irq_hit) begin
            rdata_o = irq_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/tmr_irq_ctrl.sv
`default_nettype none

module tmr_irq_ctrl (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  logic [tmr_pkg::OFS_W-1:0]  ofs_i,
    input  logic [tmr_pkg::BUS_DW-1:0] wdata_i,
    input  logic [tmr_pkg::N_TMR-1:0]  src_i,
    output logic [tmr_pkg::BUS_DW-1:0] rdata_o,
    output logic                       irq_o
);

    import tmr_pkg::*;

    // one mask bit per source, 1 lets it through
    logic [N_TMR-1:0] mask_q;

    // sources that are both raised and unmasked
    logic [N_TMR-1:0] active;

    // 1-based id of the winning source, 0 when idle
    logic [BUS_DW-1:0] irq_id;

    assign active = src_i & mask_q;
    assign irq_o  = |active;

    // mask register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q <= '0;
        end else if (we_i && (ofs_i == REG_IRQ_MASK)) begin
            mask_q <= wdata_i[N_TMR-1:0];
        end
    end

    // lowest index wins, so scan downwards
    always_comb begin
        irq_id = '0;
        for (int i = N_TMR - 1; i >= 0; i--) begin
            if (active[i]) begin
                irq_id = BUS_DW'(i + 1);
            end
        end
    end

    // read mux
    always_comb begin
        case (ofs_i)
            REG_IRQ_MASK: begin
                rdata_o = {{(BUS_DW - N_TMR){1'b0}}, mask_q};
            end
            REG_IRQ_PEND: begin
                // raw lines, mask not applied
                rdata_o = {{(BUS_DW - N_TMR){1'b0}}, src_i};
            end
            REG_IRQ_ID: begin
                rdata_o = irq_id;
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/tmr_subsys.sv
`default_nettype none

module tmr_subsys (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic [tmr_pkg::BUS_AW-1:0] addr_i,
    input  logic [tmr_pkg::BUS_DW-1:0] wdata_i,
    input  logic                       we_i,
    output logic [tmr_pkg::BUS_DW-1:0] rdata_o,
    output logic                       irq_o
);

    import tmr_pkg::*;

    // decoder to block wiring
    logic [N_TMR-1:0]             tmr_we;
    logic                         irq_we;
    logic [OFS_W-1:0]             ofs;
    logic [N_TMR-1:0][BUS_DW-1:0] tmr_rdata;
    logic [BUS_DW-1:0]            irq_rdata;

    // timer interrupt levels
    logic [N_TMR-1:0] tmr_int;

    tmr_bus_decode tmr_bus_decode_i (
        .addr_i      (addr_i),
        .we_i        (we_i),
        .tmr_rdata_i (tmr_rdata),
        .irq_rdata_i (irq_rdata),
        .tmr_we_o    (tmr_we),
        .irq_we_o    (irq_we),
        .ofs_o       (ofs),
        .rdata_o     (rdata_o)
    );

    // one timer per interrupt source, index is source id minus one
    for (genvar i = 0; i < N_TMR; i++) begin : g_tmr
        tmr_counter tmr_counter_i (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .we_i     (tmr_we[i]),
            .ofs_i    (ofs),
            .wdata_i  (wdata_i),
            .rdata_o  (tmr_rdata[i]),
            .int_o    (tmr_int[i])
        );
    end

    tmr_irq_ctrl tmr_irq_ctrl_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (irq_we),
        .ofs_i    (ofs),
        .wdata_i  (wdata_i),
        .src_i    (tmr_int),
        .rdata_o  (irq_rdata),
        .irq_o    (irq_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o,
    output logic arst_n_o
);

    // free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_tmr_subsys.sv
`default_nettype none

module tb_tmr_subsys;

    import tmr_pkg::*;

    localparam int PERIOD = 100;
    // expiry runs per timer
    localparam int N_RUNS = 3;
    // expiry runs plus reset, masking, disable and unmapped sections
    localparam int N_TESTS = 2 * N_RUNS + 4;
    localparam int WATCHDOG_CYCLES = 40 * N_TESTS + 100;

    logic              clk;
    logic              arst_n;
    logic [BUS_AW-1:0] bus_addr;
    logic [BUS_DW-1:0] bus_wdata;
    logic              bus_we;
    logic [BUS_DW-1:0] bus_rdata;
    logic              irq;

    // irq_o as seen by the last bus read
    logic        irq_seen;
    // mask as the DUT holds it after the last write
    logic [1:0]  mask_sh;
    logic [31:0] lfsr_q;
    int          err_val;
    int          err_other;

    tb_clk_gen #(.PERIOD(PERIOD)) tb_clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    tmr_subsys tmr_subsys_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .addr_i   (bus_addr),
        .wdata_i  (bus_wdata),
        .we_i     (bus_we),
        .rdata_o  (bus_rdata),
        .irq_o    (irq)
    );

    // no interrupt may leave the subsystem while in reset
    assert property (@(posedge clk) !arst_n |-> !irq)
        else begin
            err_other++;
            $display("irq_o went high while reset was asserted");
        end

    // all sources masked means a quiet interrupt line
    assert property (@(posedge clk) disable iff (!arst_n) irq |-> (mask_sh != 2'b00))
        else begin
            err_other++;
            $display("irq_o high although every source is masked");
        end

    // galois taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
            else begin
                err_val++;
                $display("ERR %s expected %08h got %08h", name, exp, got);
            end
    endtask

    // driven on a falling edge and written at the next rising edge
    task automatic bus_write(input logic [BUS_AW-1:0] a, input logic [BUS_DW-1:0] d);
        bus_addr  = a;
        bus_wdata = d;
        bus_we    = 1'b1;
        @(negedge clk);
        bus_we = 1'b0;
        if (a == BASE_IRQ + REG_IRQ_MASK) begin
            mask_sh = d[1:0];
        end
    endtask

    // sampled a quarter period after the drive and before the rising edge
    task automatic bus_read(input logic [BUS_AW-1:0] a, output logic [BUS_DW-1:0] d);
        bus_addr = a;
        bus_we   = 1'b0;
        #(PERIOD / 4);
        d        = bus_rdata;
        irq_seen = irq;
        @(negedge clk);
    endtask

    task automatic expect_read(input string name, input logic [BUS_AW-1:0] a,
                               input logic [BUS_DW-1:0] exp);
        logic [BUS_DW-1:0] got;
        bus_read(a, got);
        check_value(name, exp, got);
    endtask

    // one-shot expiry followed by pending clear
    task automatic run_expiry(input logic [BUS_AW-1:0] base);
        logic [31:0] v;
        logic [31:0] spare;
        logic [31:0] got;
        tmr_ctrl_t   c;
        draw_bits(4, v);
        v = v + 1;
        draw_bits(29, spare);
        c.raw          = '0;
        c.field.spare  = spare[28:0];
        c.field.en     = 1'b1;
        c.field.irq_en = 1'b1;
        bus_write(base + REG_VALUE, v);
        bus_write(base + REG_CTRL, c.raw);
        // count k after the k-th edge past the enable write
        for (int k = 0; k <= v; k++) begin
            bus_read(base + REG_COUNT, got);
            check_value("count", k, got);
            check_value("irq_o", 0, irq_seen);
        end
        // stopped and flagged once edge V+1 has passed
        c.field.en   = 1'b0;
        c.field.pend = 1'b1;
        expect_read("ctrl", base + REG_CTRL, c.raw);
        check_value("irq_o", 1, irq_seen);
        expect_read("count", base + REG_COUNT, 0);
        // writing 0 to pending keeps it
        c.field.pend = 1'b0;
        bus_write(base + REG_CTRL, c.raw);
        c.field.pend = 1'b1;
        expect_read("ctrl", base + REG_CTRL, c.raw);
        check_value("irq_o", 1, irq_seen);
        // writing 1 clears it
        bus_write(base + REG_CTRL, c.raw);
        c.field.pend = 1'b0;
        expect_read("ctrl", base + REG_CTRL, c.raw);
        check_value("irq_o", 0, irq_seen);
    endtask

    initial begin
        #(PERIOD * WATCHDOG_CYCLES);
        $display("timeout, run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] got;
        int          n;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_we    = 1'b0;
        irq_seen  = 1'b0;
        mask_sh   = 2'b00;
        lfsr_q    = 32'd76546;
        err_val   = 0;
        err_other = 0;
        wait (arst_n);
        @(negedge clk);
        check_value("irq_o", 0, irq);

        // reset state of every offset including 0xc
        for (int o = 0; o < 16; o += 4) begin
            expect_read("tmr0 reg", BASE_TMR0 + o, 0);
            expect_read("tmr1 reg", BASE_TMR1 + o, 0);
            expect_read("irq reg", BASE_IRQ + o, 0);
        end

        // expiry timing with both sources unmasked
        bus_write(BASE_IRQ + REG_IRQ_MASK, 32'h3);
        for (int r = 0; r < N_RUNS; r++) begin
            run_expiry(BASE_TMR0);
            run_expiry(BASE_TMR1);
        end

        // masking and priority with both timers expired
        bus_write(BASE_IRQ + REG_IRQ_MASK, 32'h0);
        draw_bits(4, v);
        bus_write(BASE_TMR0 + REG_VALUE, v + 1);
        bus_write(BASE_TMR0 + REG_CTRL, 32'h3);
        draw_bits(4, v);
        bus_write(BASE_TMR1 + REG_VALUE, v + 1);
        bus_write(BASE_TMR1 + REG_CTRL, 32'h3);
        got = '0;
        n   = 0;
        while (got != 32'h3 && n < 40) begin
            bus_read(BASE_IRQ + REG_IRQ_PEND, got);
            n++;
        end
        assert (got == 32'h3)
            else begin
                err_other++;
                $display("timers did not both expire within 40 cycles");
            end
        expect_read("irq id", BASE_IRQ + REG_IRQ_ID, 0);
        check_value("irq_o", 0, irq_seen);
        bus_write(BASE_IRQ + REG_IRQ_MASK, 32'h2);
        expect_read("irq mask", BASE_IRQ + REG_IRQ_MASK, 32'h2);
        expect_read("irq id", BASE_IRQ + REG_IRQ_ID, 2);
        check_value("irq_o", 1, irq_seen);
        expect_read("irq pend", BASE_IRQ + REG_IRQ_PEND, 32'h3);
        bus_write(BASE_IRQ + REG_IRQ_MASK, 32'h3);
        expect_read("irq id", BASE_IRQ + REG_IRQ_ID, 1);
        expect_read("irq pend", BASE_IRQ + REG_IRQ_PEND, 32'h3);
        bus_write(BASE_TMR0 + REG_CTRL, 32'h4);
        bus_write(BASE_TMR1 + REG_CTRL, 32'h4);

        // disable before expiry
        bus_write(BASE_TMR0 + REG_VALUE, 32'd20);
        bus_write(BASE_TMR0 + REG_CTRL, 32'h3);
        repeat (3) @(negedge clk);
        bus_write(BASE_TMR0 + REG_CTRL, 32'h2);
        // enable drops at the write edge and count clears one edge later
        @(negedge clk);
        expect_read("count", BASE_TMR0 + REG_COUNT, 0);
        repeat (25) @(negedge clk);
        expect_read("ctrl", BASE_TMR0 + REG_CTRL, 32'h2);
        expect_read("irq pend", BASE_IRQ + REG_IRQ_PEND, 0);
        check_value("irq_o", 0, irq_seen);

        // known state before writes above the map
        bus_write(BASE_TMR0 + REG_VALUE, 32'h0000_1234);
        bus_write(BASE_TMR1 + REG_VALUE, 32'h0000_5678);
        bus_write(BASE_TMR0 + REG_CTRL, 32'h0);
        bus_write(BASE_IRQ + REG_IRQ_MASK, 32'h1);
        bus_write(32'h30, 32'hFFFF_FFFF);
        bus_write(32'h38, 32'hFFFF_FFFF);
        bus_write(32'h100, 32'hFFFF_FFFF);
        bus_write(32'hFFFF_FFF0, 32'hFFFF_FFFF);
        expect_read("unmapped", 32'h30, 0);
        expect_read("unmapped", 32'h3C, 0);
        expect_read("unmapped", 32'hFFFF_FFF8, 0);
        expect_read("tmr0 ctrl", BASE_TMR0 + REG_CTRL, 0);
        expect_read("tmr0 value", BASE_TMR0 + REG_VALUE, 32'h0000_1234);
        expect_read("tmr1 ctrl", BASE_TMR1 + REG_CTRL, 0);
        expect_read("tmr1 count", BASE_TMR1 + REG_COUNT, 0);
        expect_read("tmr1 value", BASE_TMR1 + REG_VALUE, 32'h0000_5678);
        expect_read("irq mask", BASE_IRQ + REG_IRQ_MASK, 32'h1);
        check_value("irq_o", 0, irq_seen);

        $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/tmr_pkg.sv
hw/tmr_counter.sv
hw/tmr_bus_decode.sv
hw/tmr_irq_ctrl.sv
hw/tmr_subsys.sv
dv/tb_clk_gen.sv
dv/tb_tmr_subsys.sv

// File: Bender.yml
package:
  name: tmr_subsys

sources:
  - hw/tmr_pkg.sv
  - hw/tmr_counter.sv
  - hw/tmr_bus_decode.sv
  - hw/tmr_irq_ctrl.sv
  - hw/tmr_subsys.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_tmr_subsys.sv
